/* list.f */
+incdir+source
source/uart_pkg.sv
source/sync_fifo.sv
source/uart_rx.sv
source/uart_tx.sv
source/uart.sv
test/tb_clk_gen.sv
test/uart_tb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the uart testbench with verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module uart_tb --Mdir obj_dir -o uart_sim -f list.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/uart_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: PASS" <<< "$output"; then
    exit 0
else
    echo "pass message not found in simulation output"
    exit 1
fi

/* source/sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_defs.svh"

module sync_fifo #(
    parameter int unsigned WIDTH = `UART_DATA_BITS,
    parameter int unsigned DEPTH = `UART_FIFO_DEPTH
) (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic [WIDTH-1:0] wdata_i,
    input  logic             we_i,
    input  logic             re_i,
    output logic [WIDTH-1:0] rdata_o,
    output logic             full_o,
    output logic             empty_o
);

    localparam int unsigned AW = $clog2(DEPTH);

    logic [WIDTH-1:0] mem_q [DEPTH];
    logic [AW:0]      wptr_q;   // extra msb tells full from empty
    logic [AW:0]      rptr_q;
    logic             push;
    logic             pop;

    assign push = we_i && !full_o;
    assign pop  = re_i && !empty_o;

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wptr_q[AW-1:0]] <= wdata_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wptr_q <= '0;
            rptr_q <= '0;
        end else begin
            if (push) begin
                wptr_q <= wptr_q + 1'b1;
            end
            if (pop) begin
                rptr_q <= rptr_q + 1'b1;
            end
        end
    end

    assign empty_o = (wptr_q == rptr_q);
    assign full_o  = (wptr_q[AW] != rptr_q[AW]) &&
                     (wptr_q[AW-1:0] == rptr_q[AW-1:0]);

    assign rdata_o = mem_q[rptr_q[AW-1:0]];  // show-ahead head entry

endmodule

`default_nettype wire

/* source/uart.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_defs.svh"

module uart
    import uart_pkg::*;
#(
    parameter int unsigned BAUD_DIV = `UART_BAUD_DIV
) (
    input  logic  clk_i,
    input  logic  rst_ni,
    input  logic  uart_rx_i,
    input  logic  uart_we_i,
    input  logic  uart_re_i,
    input  word_t uart_tx_wdata_i,
    output word_t uart_rx_rdata_o,
    output logic  uart_tx_o,
    output irq_t  uart_irq_o,
    input  logic  uart_ce_i,
    input  logic  uart_req_i,
    output logic  uart_gnt_o
);

    byte_t rx_byte;
    logic  rx_valid;
    byte_t rx_fifo_data;
    logic  rx_fifo_full;
    logic  rx_fifo_empty;
    logic  rx_push;
    logic  rx_pop;

    byte_t tx_fifo_data;
    logic  tx_fifo_full;
    logic  tx_fifo_empty;
    logic  tx_push;
    logic  tx_pop;

    assign rx_push = rx_valid && !rx_fifo_full;  // byte lost when queue is full
    assign rx_pop  = uart_re_i && !rx_fifo_empty;
    assign tx_push = uart_we_i && !tx_fifo_full;

    uart_rx #(
        .BAUD_DIV (BAUD_DIV)
    ) rx_i (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .rx_i       (uart_rx_i),
        .rx_byte_o  (rx_byte),
        .rx_valid_o (rx_valid)
    );

    sync_fifo #(
        .WIDTH ($bits(byte_t)),
        .DEPTH (`UART_FIFO_DEPTH)
    ) rx_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .wdata_i (rx_byte),
        .we_i    (rx_push),
        .re_i    (rx_pop),
        .rdata_o (rx_fifo_data),
        .full_o  (rx_fifo_full),
        .empty_o (rx_fifo_empty)
    );

    sync_fifo #(
        .WIDTH ($bits(byte_t)),
        .DEPTH (`UART_FIFO_DEPTH)
    ) tx_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .wdata_i (uart_tx_wdata_i[`UART_DATA_BITS-1:0]),
        .we_i    (tx_push),
        .re_i    (tx_pop),
        .rdata_o (tx_fifo_data),
        .full_o  (tx_fifo_full),
        .empty_o (tx_fifo_empty)
    );

    uart_tx #(
        .BAUD_DIV (BAUD_DIV)
    ) tx_i (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .fifo_data_i  (tx_fifo_data),
        .fifo_empty_i (tx_fifo_empty),
        .fifo_pop_o   (tx_pop),
        .tx_o         (uart_tx_o)
    );

    assign uart_rx_rdata_o = word_t'(rx_fifo_data);  // zero-extended head
    assign uart_irq_o      = {tx_fifo_full, !rx_fifo_empty};
    assign uart_gnt_o      = uart_req_i && uart_ce_i;

endmodule

`default_nettype wire

/* source/uart_defs.svh */
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

// clock cycles per bit, 9600 baud at 12 MHz
`define UART_BAUD_DIV 16'd1250

// entries in each of the rx and tx queues, power of two
`define UART_FIFO_DEPTH 32

// 8N1 frame
`define UART_DATA_BITS 8

// receive line synchronizer depth
`define UART_SYNC_STAGES 3

`endif

/* source/uart_pkg.sv */
`default_nettype none

`include "uart_defs.svh"

package uart_pkg;

    typedef logic [`UART_DATA_BITS-1:0] byte_t;
    typedef logic [31:0]                word_t;      // bus data word
    typedef logic [15:0]                baud_cnt_t;  // bit period counter
    typedef logic [3:0]                 bit_cnt_t;   // bits within a frame
    typedef logic [1:0]                 irq_t;       // {tx full, rx available}

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

endpackage

`default_nettype wire

/* source/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_defs.svh"

module uart_rx
    import uart_pkg::*;
#(
    parameter int unsigned BAUD_DIV = `UART_BAUD_DIV
) (
    input  logic  clk_i,
    input  logic  rst_ni,
    input  logic  rx_i,
    output byte_t rx_byte_o,
    output logic  rx_valid_o
);

    localparam int unsigned NSYNC = `UART_SYNC_STAGES;
    localparam baud_cnt_t   HALF  = baud_cnt_t'(BAUD_DIV / 2 - 1);
    localparam baud_cnt_t   FULL  = baud_cnt_t'(BAUD_DIV - 1);
    localparam bit_cnt_t    LAST  = bit_cnt_t'(`UART_DATA_BITS - 1);

    logic [NSYNC-1:0] sync_q;
    logic             rx_s;
    logic             rx_fall;
    rx_state_e        state_q;
    baud_cnt_t        cnt_q;
    bit_cnt_t         bit_cnt_q;
    byte_t            shift_q;
    logic             tick;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sync_q <= '1;  // idle line is high
        end else begin
            sync_q <= {sync_q[NSYNC-2:0], rx_i};
        end
    end

    // last stage only serves the edge detect
    assign rx_s    = sync_q[NSYNC-2];
    assign rx_fall = sync_q[NSYNC-1] && !rx_s;

    // mid-bit sample point
    assign tick = (state_q != RX_IDLE) && (cnt_q == '0);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= RX_IDLE;
            cnt_q      <= HALF;
            bit_cnt_q  <= '0;
            rx_valid_o <= 1'b0;
        end else begin
            rx_valid_o <= 1'b0;
            if (state_q == RX_IDLE) begin
                cnt_q <= HALF;  // half period to the start bit middle
            end else if (tick) begin
                cnt_q <= FULL;
            end else begin
                cnt_q <= cnt_q - 1'b1;
            end

            case (state_q)
                RX_IDLE: begin
                    if (rx_fall) begin
                        state_q <= RX_START;
                    end
                end
                RX_START: begin
                    if (tick) begin
                        bit_cnt_q <= '0;
                        state_q   <= rx_s ? RX_IDLE : RX_DATA;  // high means glitch
                    end
                end
                RX_DATA: begin
                    if (tick) begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                        if (bit_cnt_q == LAST) begin
                            state_q <= RX_STOP;
                        end
                    end
                end
                default: begin
                    if (tick) begin
                        rx_valid_o <= rx_s;  // low stop bit drops the frame
                        state_q    <= RX_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (tick && state_q == RX_DATA) begin
            shift_q <= {rx_s, shift_q[$bits(byte_t)-1:1]};  // lsb first
        end
    end

    assign rx_byte_o = shift_q;

endmodule

`default_nettype wire

/* source/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_defs.svh"

module uart_tx
    import uart_pkg::*;
#(
    parameter int unsigned BAUD_DIV = `UART_BAUD_DIV
) (
    input  logic  clk_i,
    input  logic  rst_ni,
    input  byte_t fifo_data_i,
    input  logic  fifo_empty_i,
    output logic  fifo_pop_o,
    output logic  tx_o
);

    localparam baud_cnt_t FULL = baud_cnt_t'(BAUD_DIV - 1);
    localparam bit_cnt_t  LAST = bit_cnt_t'(`UART_DATA_BITS);

    baud_cnt_t cnt_q;
    tx_state_e state_q;
    bit_cnt_t  bit_cnt_q;   // data bits already on the line
    byte_t     shift_q;
    logic      tx_q;
    logic      tick;
    logic      load;

    assign tick = (cnt_q == FULL);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= tick ? '0 : cnt_q + 1'b1;  // free running
        end
    end

    // a new frame may follow the stop bit directly
    assign load = tick && !fifo_empty_i && (state_q == TX_IDLE || state_q == TX_STOP);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= TX_IDLE;
            bit_cnt_q <= '0;
            tx_q      <= 1'b1;
        end else if (load) begin
            state_q <= TX_START;
            tx_q    <= 1'b0;  // start bit
        end else if (tick) begin
            case (state_q)
                TX_START: begin
                    tx_q      <= shift_q[0];
                    bit_cnt_q <= bit_cnt_t'(1);
                    state_q   <= TX_DATA;
                end
                TX_DATA: begin
                    if (bit_cnt_q == LAST) begin
                        tx_q    <= 1'b1;  // stop bit
                        state_q <= TX_STOP;
                    end else begin
                        tx_q      <= shift_q[0];
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                    end
                end
                default: begin
                    state_q <= TX_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            shift_q <= fifo_data_i;
        end else if (tick && (state_q == TX_START || state_q == TX_DATA)) begin
            shift_q <= shift_q >> 1;
        end
    end

    assign fifo_pop_o = load;
    assign tx_o       = tx_q;

endmodule

`default_nettype wire

/* test/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int unsigned HALF_PERIOD_NS = 50  // 100 ns period
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(HALF_PERIOD_NS * 1ns) clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

/* test/uart_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_defs.svh"

module uart_tb
    import uart_pkg::*;
();

    localparam int unsigned BAUD_DIV       = 16;
    localparam int unsigned DEPTH          = `UART_FIFO_DEPTH;
    localparam int unsigned TIMEOUT_CYCLES = 40 * 10 * BAUD_DIV * 2;

    logic  clk;
    logic  rst_n;
    logic  rx_line;
    logic  loopback;
    logic  uart_rx;
    logic  uart_we;
    logic  uart_re;
    word_t uart_wdata;
    word_t uart_rdata;
    logic  uart_tx;
    irq_t  uart_irq;
    logic  uart_ce;
    logic  uart_req;
    logic  uart_gnt;

    integer      seed = 32'h268c_dd86;
    int unsigned cycle_cnt = 0;
    int unsigned checks = 0;
    int unsigned fails = 0;
    int unsigned checks_at_start;
    int unsigned fails_at_start;
    byte_t       exp_q [$];
    logic        full_seen;

    tb_clk_gen clk_gen_i (
        .clk_o (clk)
    );

    assign uart_rx = loopback ? uart_tx : rx_line;

    uart #(
        .BAUD_DIV (BAUD_DIV)
    ) uart_i (
        .clk_i           (clk),
        .rst_ni          (rst_n),
        .uart_rx_i       (uart_rx),
        .uart_we_i       (uart_we),
        .uart_re_i       (uart_re),
        .uart_tx_wdata_i (uart_wdata),
        .uart_rx_rdata_o (uart_rdata),
        .uart_tx_o       (uart_tx),
        .uart_irq_o      (uart_irq),
        .uart_ce_i       (uart_ce),
        .uart_req_i      (uart_req),
        .uart_gnt_o      (uart_gnt)
    );

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
            fails++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond === 1'b1) else begin
            $display("error: %s", what);
            fails++;
        end
    endtask

    task automatic start_test();
        checks_at_start = checks;
        fails_at_start  = fails;
    endtask

    task automatic end_test(input string name);
        $display("test %s: %0d checks, %0d errors", name,
                 checks - checks_at_start, fails - fails_at_start);
    endtask

    // one 8N1 frame on the rx line, then one idle bit
    task automatic send_frame(input byte_t data, input logic stop_bit);
        logic [9:0] frame;
        frame = {stop_bit, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rx_line <= frame[i];
            repeat (BAUD_DIV - 1) @(posedge clk);
        end
        @(posedge clk);
        rx_line <= 1'b1;
        repeat (BAUD_DIV) @(posedge clk);
    endtask

    task automatic decode_frame(output byte_t data);
        do @(negedge clk); while (uart_tx !== 1'b0);  // start edge
        repeat (BAUD_DIV / 2) @(negedge clk);
        check_value("uart_tx_o start bit", 32'(uart_tx), 32'h0);
        for (int i = 0; i < 8; i++) begin
            repeat (BAUD_DIV) @(negedge clk);
            data[i] = uart_tx;  // lsb first
        end
        repeat (BAUD_DIV) @(negedge clk);
        check_value("uart_tx_o stop bit", 32'(uart_tx), 32'h1);
    endtask

    // writes on consecutive cycles, keeps the bytes the tx queue takes
    task automatic write_burst(input int count);
        word_t word;
        for (int i = 0; i < count; i++) begin
            word = $random(seed);
            @(posedge clk);
            uart_we    <= 1'b1;
            uart_wdata <= word;  // upper bits are junk on purpose
            @(negedge clk);
            if (uart_irq[1]) begin
                full_seen = 1'b1;
            end else begin
                exp_q.push_back(word[7:0]);
            end
        end
        @(posedge clk);
        uart_we <= 1'b0;
    endtask

    // called at a falling edge with the rx queue not empty
    task automatic pop_rx(output byte_t data);
        check_value("uart_rx_rdata_o[31:8]", 32'(uart_rdata[31:8]), 32'h0);
        data = uart_rdata[7:0];
        @(posedge clk);
        uart_re <= 1'b1;
        @(posedge clk);
        uart_re <= 1'b0;
    endtask

    initial begin
        byte_t data;
        byte_t got;
        rst_n      = 1'b0;
        rx_line    = 1'b1;
        loopback   = 1'b0;
        uart_we    = 1'b0;
        uart_re    = 1'b0;
        uart_wdata = '0;
        uart_ce    = 1'b0;
        uart_req   = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        start_test();
        @(negedge clk);
        check_value("uart_tx_o", 32'(uart_tx), 32'h1);
        check_value("uart_irq_o", 32'(uart_irq), 32'h0);
        check_value("uart_rx_rdata_o[31:8]", 32'(uart_rdata[31:8]), 32'h0);
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            uart_req <= i[1];
            uart_ce  <= i[0];
            @(negedge clk);
            check_value("uart_gnt_o", 32'(uart_gnt), 32'(i == 3));
        end
        end_test("reset and grant");

        start_test();
        fork
            write_burst(4);
            for (int i = 0; i < 4; i++) begin
                decode_frame(got);
                check_value("uart_tx_o byte", 32'(got), 32'(exp_q.pop_front()));
            end
        join
        end_test("transmit frame");

        start_test();
        for (int i = 0; i < 4; i++) begin
            data = byte_t'($random(seed));
            exp_q.push_back(data);
            send_frame(data, 1'b1);
            @(negedge clk);
            check_value("uart_irq_o[0]", 32'(uart_irq[0]), 32'h1);
        end
        while (exp_q.size() > 0) begin
            @(negedge clk);
            pop_rx(got);
            check_value("uart_rx_rdata_o", 32'(got), 32'(exp_q.pop_front()));
        end
        @(negedge clk);
        check_value("uart_irq_o[0]", 32'(uart_irq[0]), 32'h0);
        end_test("receive");

        start_test();
        send_frame(byte_t'($random(seed)), 1'b0);  // stop bit low
        @(negedge clk);
        check_value("uart_irq_o[0]", 32'(uart_irq[0]), 32'h0);
        data = byte_t'($random(seed));
        send_frame(data, 1'b1);
        @(negedge clk);
        check_value("uart_irq_o[0]", 32'(uart_irq[0]), 32'h1);
        pop_rx(got);
        check_value("uart_rx_rdata_o", 32'(got), 32'(data));
        @(negedge clk);
        check_value("uart_irq_o[0]", 32'(uart_irq[0]), 32'h0);
        end_test("framing error");

        start_test();
        @(posedge clk);
        loopback <= 1'b1;
        exp_q.delete();
        full_seen = 1'b0;
        write_burst(DEPTH + 3);
        check_true(full_seen, "tx full flag was never seen high during the burst");
        while (exp_q.size() > 0) begin
            @(negedge clk);
            if (uart_irq[0]) begin
                pop_rx(got);
                check_value("uart_rx_rdata_o", 32'(got), 32'(exp_q.pop_front()));
            end
        end
        @(negedge clk);
        check_value("uart_irq_o", 32'(uart_irq), 32'h0);
        @(posedge clk);
        loopback <= 1'b0;
        end_test("loopback and full flag");

        $display("summary: %0d checks passed, %0d failed", checks - fails, fails);
        if (fails == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
